/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := compress_tb
FILELIST  := compress_top.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf obj_dir

/* coeff_compressor.sv */
// ##########################################################################
// Compress_d stage, four coefficients per cycle, one register deep
// ##########################################################################
`default_nettype none
`timescale 1ns/1ps

module coeff_compressor (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize,
    compress_stage_if.sink    s0,
    compress_stage_if.source  s1
);
    import compress_params_pkg::*;
    import compress_defines_pkg::*;

    logic [3:0] d;
    mem_data_t  cmp_data;

    // round(x * 2^d / q) mod 2^d, divide by reciprocal multiply
    function automatic cmp_coeff_t compress_coeff(coeff_t x, logic [3:0] dbits);
        logic [23:0] num;
        logic [36:0] prod;
        logic [12:0] quo;
        logic [24:0] rem;
        logic [12:0] mask;
        num  = (24'(x) << dbits) + 24'(cmp_round);
        prod = 37'(num) * 37'(cmp_recip);
        quo  = 13'(prod >> cmp_recip_shift);
        // Estimate can be one low
        rem  = 25'(num) - 25'(quo) * 25'(mlkem_q);
        if (rem >= 25'(mlkem_q)) begin
            quo = quo + 13'd1;
        end
        mask = (13'd1 << dbits) - 13'd1;
        return cmp_coeff_t'(quo & mask);
    endfunction

    always_comb begin
        d = mode_bits(s0.mode);
        for (int k = 0; k < coeffs_per_word; k++) begin
            cmp_data[coeff_width*k +: coeff_width] =
                compress_coeff(s0.data[coeff_width*k +: coeff_width], d);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1.valid <= 1'b0;
            s1.last  <= 1'b0;
            s1.mode  <= compress1;
        end else if (zeroize) begin
            s1.valid <= 1'b0;
            s1.last  <= 1'b0;
            s1.mode  <= compress1;
        end else begin
            s1.valid <= s0.valid;
            s1.last  <= s0.valid & s0.last;
            s1.mode  <= s0.mode;
        end
    end

    always_ff @(posedge clk) begin
        if (s0.valid) begin
            s1.data <= cmp_data;
        end
    end

endmodule

`default_nettype wire

/* compress_assertions.sv */
// ##########################################################################
// Protocol assertions on the compression engine top-level ports
// ##########################################################################
`default_nettype none
`timescale 1ns/1ps

module compress_assertions (
    input logic clk,
    input logic reset_n,
    input logic zeroize,
    input logic start,
    input logic busy,
    input logic done,
    input logic out_valid
);

    done_quiet_in_reset: assert property (@(posedge clk) !reset_n |-> (!done && !out_valid))
        else $error("done or out_valid high during reset");

    done_single_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        done |=> !done)
        else $error("done high on two consecutive cycles");

    // Output has stopped once busy has been low for three cycles
    no_output_when_idle: assert property (@(posedge clk) disable iff (!reset_n)
        (!busy && !$past(busy) && !$past(busy, 2)) |-> !out_valid)
        else $error("out_valid while busy low for three cycles");

    start_sets_busy: assert property (@(posedge clk) disable iff (!reset_n)
        (start && !busy && !zeroize) |=> busy)
        else $error("start while idle not followed by busy");

endmodule

bind compress_top compress_assertions assert_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize   (zeroize),
    .start     (start),
    .busy      (busy),
    .done      (done),
    .out_valid (out_valid)
);

`default_nettype wire

/* compress_ctrl.sv */
// ##########################################################################
// Read controller, paced address walk over num_poly polynomials
// ##########################################################################
`default_nettype none
`timescale 1ns/1ps

module compress_ctrl (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 zeroize,
    input  logic                                 start,
    input  compress_defines_pkg::compress_mode_t mode,
    input  compress_params_pkg::num_poly_t       num_poly,
    input  compress_params_pkg::mem_addr_t       src_base_addr,
    input  logic                                 pipe_done,
    output logic                                 rd_en,
    output compress_params_pkg::mem_addr_t       rd_addr,
    output logic                                 rd_last,
    output compress_defines_pkg::compress_mode_t rd_mode,
    output logic                                 busy
);
    import compress_params_pkg::*;
    import compress_defines_pkg::*;

    cmp_read_state_e        state, state_next;
    compress_mode_t         mode_q;
    num_poly_t              num_poly_q;
    mem_addr_t              base_q;
    mem_addr_t              addr;
    mem_addr_t              last_addr;
    logic [pace_width-1:0]  pace;
    logic [pace_width-1:0]  pace_init;
    logic                   start_rd;
    logic                   last_rd;
    rw_cmd_e                rd_cmd;

    // Read patterns sized so the packer buffer never overflows
    always_comb begin
        case (mode)
            compress11: pace_init = 12'b0011_0111_0111;
            compress12: pace_init = 12'b0110_1101_1011;
            default:    pace_init = '1;
        endcase
    end

    always_comb begin
        start_rd  = (state == cmp_rd_idle) && start;
        rd_cmd    = ((state == cmp_rd_mem) && pace[0] && !zeroize) ? rw_read : rw_idle;
        last_addr = base_q + mem_addr_t'(num_poly_q * words_per_poly) - mem_addr_t'(1);
        last_rd   = (rd_cmd == rw_read) && (addr == last_addr);
    end

    always_comb begin
        state_next = state;
        case (state)
            cmp_rd_idle:  if (start_rd)  state_next = cmp_rd_mem;
            cmp_rd_mem:   if (last_rd)   state_next = cmp_rd_drain;
            cmp_rd_drain: if (pipe_done) state_next = cmp_rd_idle;
            default:      state_next = cmp_rd_idle;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= cmp_rd_idle;
        end else if (zeroize) begin
            state <= cmp_rd_idle;
        end else begin
            state <= state_next;
        end
    end

    // Run settings held for the whole run
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mode_q     <= compress1;
            num_poly_q <= '0;
            base_q     <= '0;
        end else if (start_rd) begin
            mode_q     <= mode;
            num_poly_q <= num_poly;
            base_q     <= src_base_addr;
        end
    end

    // compress12 rotates, compress11 shifts over an 11-cycle period
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pace <= '0;
        end else if (zeroize) begin
            pace <= '0;
        end else if (start_rd) begin
            pace <= pace_init;
        end else if ((state == cmp_rd_mem) && (mode_q == compress12)) begin
            pace <= {pace[0], pace[pace_width-1:1]};
        end else if ((state == cmp_rd_mem) && (mode_q == compress11)) begin
            pace <= {1'b0, pace[0], pace[pace_width-2:1]};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            addr <= '0;
        end else if (zeroize) begin
            addr <= '0;
        end else if (start_rd) begin
            addr <= src_base_addr;
        end else if (rd_cmd == rw_read) begin
            addr <= addr + mem_addr_t'(1);
        end
    end

    assign rd_en   = (rd_cmd == rw_read);
    assign rd_addr = addr;
    assign rd_last = last_rd;
    assign rd_mode = mode_q;
    assign busy    = (state != cmp_rd_idle);

endmodule

`default_nettype wire

/* compress_defines_pkg.sv */
// ##########################################################################
// Compression modes, read FSM states and memory commands
// ##########################################################################
`default_nettype none

package compress_defines_pkg;

    typedef enum logic [1:0] {
        compress1  = 2'd0,
        compress5  = 2'd1,
        compress11 = 2'd2,
        compress12 = 2'd3
    } compress_mode_t;

    typedef enum logic [1:0] {
        cmp_rd_idle  = 2'd0,
        cmp_rd_mem   = 2'd1,
        cmp_rd_drain = 2'd2
    } cmp_read_state_e;

    typedef enum logic {
        rw_idle = 1'b0,
        rw_read = 1'b1
    } rw_cmd_e;

    // Number of bits d kept per coefficient
    function automatic logic [3:0] mode_bits(compress_mode_t mode);
        case (mode)
            compress1:  return 4'd1;
            compress5:  return 4'd5;
            compress11: return 4'd11;
            default:    return 4'd12;
        endcase
    endfunction

endpackage

`default_nettype wire

/* compress_packer.sv */
// ##########################################################################
// Bit packer, little-endian stream of 32-bit words plus run completion
// ##########################################################################
`default_nettype none
`timescale 1ns/1ps

module compress_packer (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize,
    compress_stage_if.sink                  s1,
    output logic                            out_valid,
    output compress_params_pkg::out_word_t  out_data,
    output logic                            done
);
    import compress_params_pkg::*;
    import compress_defines_pkg::*;

    logic [pack_buf_width-1:0]  bit_buf, buf_sh, buf_next;
    logic [pack_fill_width-1:0] fill, fill_sh, fill_next;
    logic [5:0]                 grp_bits;
    mem_data_t                  group;
    logic                       emit;
    logic                       last_pending;
    logic                       finish;

    // Squeeze the four d-bit values together, coefficient 0 lowest
    always_comb begin
        grp_bits = 6'(coeffs_per_word * mode_bits(s1.mode));
        case (s1.mode)
            compress1:  group = mem_data_t'({s1.data[36], s1.data[24],
                                             s1.data[12], s1.data[0]});
            compress5:  group = mem_data_t'({s1.data[40:36], s1.data[28:24],
                                             s1.data[16:12], s1.data[4:0]});
            compress11: group = mem_data_t'({s1.data[46:36], s1.data[34:24],
                                             s1.data[22:12], s1.data[10:0]});
            default:    group = s1.data;
        endcase
    end

    always_comb begin
        emit      = (fill >= pack_fill_width'(out_width));
        buf_sh    = emit ? (bit_buf >> out_width) : bit_buf;
        fill_sh   = emit ? (fill - pack_fill_width'(out_width)) : fill;
        buf_next  = buf_sh;
        fill_next = fill_sh;
        if (s1.valid) begin
            buf_next  = buf_sh | (pack_buf_width'(group) << fill_sh);
            fill_next = fill_sh + pack_fill_width'(grp_bits);
        end
        // Last group seen and every bit of it already sent
        finish = last_pending && (fill == '0);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bit_buf      <= '0;
            fill         <= '0;
            out_valid    <= 1'b0;
            out_data     <= '0;
            last_pending <= 1'b0;
            done         <= 1'b0;
        end else if (zeroize) begin
            bit_buf      <= '0;
            fill         <= '0;
            out_valid    <= 1'b0;
            out_data     <= '0;
            last_pending <= 1'b0;
            done         <= 1'b0;
        end else begin
            bit_buf   <= buf_next;
            fill      <= fill_next;
            out_valid <= emit;
            if (emit) begin
                out_data <= bit_buf[out_width-1:0];
            end
            if (s1.valid && s1.last) begin
                last_pending <= 1'b1;
            end else if (finish) begin
                last_pending <= 1'b0;
            end
            done <= finish;
        end
    end

endmodule

`default_nettype wire

/* compress_params_pkg.sv */
// ##########################################################################
// ML-KEM compression constants, memory geometry and shared vector types
// ##########################################################################
`default_nettype none

package compress_params_pkg;

    localparam int mlkem_q         = 3329;
    localparam int mlkem_n         = 256;
    localparam int coeffs_per_word = 4;
    localparam int words_per_poly  = mlkem_n / coeffs_per_word;
    localparam int mem_addr_width  = 9;
    localparam int mem_depth       = 512;
    localparam int coeff_width     = 12;
    localparam int out_width       = 32;
    localparam int pace_width      = 12;

    // Rounding term and reciprocal for the divide by q
    localparam int cmp_round       = 1664;
    localparam int cmp_recip       = 5039;
    localparam int cmp_recip_shift = 24;

    // Packer bit buffer and its fill counter
    localparam int pack_buf_width  = 96;
    localparam int pack_fill_width = 7;

    typedef logic [coeff_width-1:0]                 coeff_t;
    typedef logic [mem_addr_width-1:0]              mem_addr_t;
    typedef logic [coeffs_per_word*coeff_width-1:0] mem_data_t;
    typedef logic [coeff_width-1:0]                 cmp_coeff_t;
    typedef logic [out_width-1:0]                   out_word_t;
    typedef logic [2:0]                             num_poly_t;

endpackage

`default_nettype wire

/* compress_stage_if.sv */
// ##########################################################################
// Stage link carrying one group of four coefficients with its tags
// ##########################################################################
`default_nettype none
`timescale 1ns/1ps

interface compress_stage_if;
    import compress_params_pkg::*;
    import compress_defines_pkg::*;

    logic           valid;
    logic           last;
    // Raw words on s0, four compressed values in 12-bit lanes on s1
    mem_data_t      data;
    compress_mode_t mode;

    modport source (output valid, output last, output data, output mode);
    modport sink   (input valid, input last, input data, input mode);

endinterface

`default_nettype wire

/* compress_tb.sv */
// ##########################################################################
// Compression engine testbench, table of runs checked against a reference
// ##########################################################################
`default_nettype none
`timescale 1ns/1ps

module compress_clk_gen (
    output logic clk
);
    // 4 ns period
    initial begin
        clk = 1'b0;
    end

    always begin
        #2 clk = ~clk;
    end

endmodule

module compress_tb;
    import compress_params_pkg::*;
    import compress_defines_pkg::*;

    typedef struct packed {
        compress_mode_t mode;
        int             num_poly;
        int             base;
        int             zero_at;
        int             restart_at;
        int             words;
    } run_t;

    localparam int num_runs    = 8;
    localparam int run_timeout = 3000;
    localparam int idle_limit  = 50;

    // mode, num_poly, base, zeroize cycle, second start cycle, word count
    localparam run_t runs [num_runs] = '{
        '{compress1,  1,   0,  0,  0,   8},
        '{compress5,  2,  37,  0,  0,  80},
        '{compress11, 3, 100,  0,  0, 264},
        '{compress12, 4, 200,  0,  0, 384},
        '{compress12, 1,   5, 40,  0,   0},
        '{compress11, 2, 300,  0,  0, 176},
        '{compress5,  1,  64,  0, 20,  40},
        '{compress1,  4, 250,  0,  0,  32}
    };

    logic           clk;
    logic           reset_n;
    logic           zeroize;
    logic           wr_en;
    mem_addr_t      wr_addr;
    mem_data_t      wr_data;
    logic           start;
    compress_mode_t mode;
    num_poly_t      num_poly;
    mem_addr_t      src_base_addr;
    logic           out_valid;
    out_word_t      out_data;
    logic           busy;
    logic           done;

    mem_data_t      mem_model [mem_depth];
    out_word_t      exp_q [$];
    out_word_t      got_q [$];
    int             value_errors;
    int             other_errors;

    compress_clk_gen clk_gen_i (
        .clk (clk)
    );

    compress_top dut_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .start         (start),
        .mode          (mode),
        .num_poly      (num_poly),
        .src_base_addr (src_base_addr),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .busy          (busy),
        .done          (done)
    );

    function automatic int bits_for_mode(compress_mode_t m);
        case (m)
            compress1:  return 1;
            compress5:  return 5;
            compress11: return 11;
            default:    return 12;
        endcase
    endfunction

    // Compress_d by plain integer division, rounded to nearest
    function automatic int compress_value(int x, int d);
        return ((x << d) + mlkem_q / 2) / mlkem_q % (1 << d);
    endfunction

    // Reference stream, little-endian bit order, coefficient 0 first
    task automatic build_expected(input run_t run);
        logic [63:0] acc;
        int          fill;
        int          d;
        int          v;
        mem_addr_t   addr;
        exp_q.delete();
        acc  = '0;
        fill = 0;
        d    = bits_for_mode(run.mode);
        for (int w = 0; w < run.num_poly * words_per_poly; w++) begin
            addr = mem_addr_t'(run.base + w);
            for (int c = 0; c < coeffs_per_word; c++) begin
                v    = compress_value(int'(mem_model[addr][coeff_width*c +: coeff_width]), d);
                acc  = acc | (64'(v) << fill);
                fill = fill + d;
                if (fill >= 32) begin
                    exp_q.push_back(acc[31:0]);
                    acc  = acc >> 32;
                    fill = fill - 32;
                end
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_quiet(input string where);
        if (out_valid || done || busy) begin
            other_errors++;
            $display("ERROR: out_valid, done or busy high %s", where);
        end
    endtask

    task automatic apply_reset();
        reset_n = 1'b0;
        for (int i = 0; i < 10; i++) begin
            next_cycle();
            check_quiet("during reset");
        end
        reset_n = 1'b1;
        next_cycle();
        check_quiet("after reset");
    endtask

    task automatic load_memory();
        for (int a = 0; a < mem_depth; a++) begin
            wr_en   = 1'b1;
            wr_addr = mem_addr_t'(a);
            for (int k = 0; k < coeffs_per_word; k++) begin
                wr_data[coeff_width*k +: coeff_width] = coeff_t'($urandom % mlkem_q);
            end
            mem_model[wr_addr] = wr_data;
            next_cycle();
        end
        wr_en = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < idle_limit) begin
            next_cycle();
            n++;
        end
        if (busy) begin
            other_errors++;
            $display("ERROR: busy still high %0d cycles after the previous run", n);
        end
    endtask

    task automatic run_one(input int r);
        run_t run;
        int   c;
        int   stop_at;
        logic done_seen;
        logic exp_busy;
        run = runs[r];
        build_expected(run);
        got_q.delete();
        wait_idle();
        start         = 1'b1;
        mode          = run.mode;
        num_poly      = num_poly_t'(run.num_poly);
        src_base_addr = mem_addr_t'(run.base);
        done_seen     = 1'b0;
        stop_at       = (run.zero_at != 0) ? run.zero_at + 6 : 0;
        c             = 0;
        while (c < run_timeout && !(stop_at != 0 && c >= stop_at)) begin
            next_cycle();
            c++;
            if (run.zero_at != 0 && c > run.zero_at) begin
                if (c >= run.zero_at + 3 && (busy || out_valid)) begin
                    other_errors++;
                    $display("ERROR: run%0d zeroize did not stop the run by cycle %0d", r, c);
                end
            end else begin
                // High from the cycle after start through the done cycle
                exp_busy = !done_seen;
                if (busy != exp_busy) begin
                    value_errors++;
                    $display("FAILED run%0d busy cycle %0d: expected %b, got %b",
                             r, c, exp_busy, busy);
                end
            end
            if (out_valid) begin
                if (done_seen) begin
                    other_errors++;
                    $display("ERROR: run%0d output word after done", r);
                end
                got_q.push_back(out_data);
            end
            if (done) begin
                if (done_seen) begin
                    other_errors++;
                    $display("ERROR: run%0d done pulsed more than once", r);
                end
                done_seen = 1'b1;
                stop_at   = c + 4;
            end
            // A second start uses another base, which must be ignored
            start         = (c == run.restart_at);
            src_base_addr = start ? mem_addr_t'(run.base + 128) : mem_addr_t'(run.base);
            zeroize       = (run.zero_at != 0) && (c == run.zero_at);
        end
        start   = 1'b0;
        zeroize = 1'b0;
        if (run.zero_at == 0) begin
            if (!done_seen) begin
                other_errors++;
                $display("ERROR: run%0d done did not arrive within %0d cycles", r, run_timeout);
            end
            if (got_q.size() != run.words) begin
                value_errors++;
                $display("FAILED run%0d word count: expected %0d, got %0d",
                         r, run.words, got_q.size());
            end
        end
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            if (got_q[i] != exp_q[i]) begin
                value_errors++;
                $display("FAILED run%0d word %0d: expected %h, got %h",
                         r, i, exp_q[i], got_q[i]);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h54f8_32cd));
        reset_n       = 1'b0;
        zeroize       = 1'b0;
        wr_en         = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        start         = 1'b0;
        mode          = compress1;
        num_poly      = '0;
        src_base_addr = '0;
        value_errors  = 0;
        other_errors  = 0;
        apply_reset();
        load_memory();
        for (int r = 0; r < num_runs; r++) begin
            run_one(r);
        end
        $display("compress_tb: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compress_top.f */
compress_params_pkg.sv
compress_defines_pkg.sv
compress_stage_if.sv
poly_coeff_mem.sv
compress_ctrl.sv
coeff_compressor.sv
compress_packer.sv
compress_top.sv
compress_assertions.sv
compress_tb.sv

/* compress_top.sv */
// ##########################################################################
// ML-KEM compression engine top, memory through packer
// ##########################################################################
`default_nettype none
`timescale 1ns/1ps

module compress_top (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 zeroize,
    input  logic                                 wr_en,
    input  compress_params_pkg::mem_addr_t       wr_addr,
    input  compress_params_pkg::mem_data_t       wr_data,
    input  logic                                 start,
    input  compress_defines_pkg::compress_mode_t mode,
    input  compress_params_pkg::num_poly_t       num_poly,
    input  compress_params_pkg::mem_addr_t       src_base_addr,
    output logic                                 out_valid,
    output compress_params_pkg::out_word_t       out_data,
    output logic                                 busy,
    output logic                                 done
);
    import compress_params_pkg::*;
    import compress_defines_pkg::*;

    logic           rd_en;
    mem_addr_t      rd_addr;
    logic           rd_last;
    compress_mode_t rd_mode;

    // Raw words, then compressed groups
    compress_stage_if s0 ();
    compress_stage_if s1 ();

    compress_ctrl ctrl_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .start         (start),
        .mode          (mode),
        .num_poly      (num_poly),
        .src_base_addr (src_base_addr),
        .pipe_done     (done),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_last       (rd_last),
        .rd_mode       (rd_mode),
        .busy          (busy)
    );

    poly_coeff_mem mem_i (
        .clk     (clk),
        .reset_n (reset_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_last (rd_last),
        .rd_mode (rd_mode),
        .s0      (s0.source)
    );

    coeff_compressor cmp_i (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .s0      (s0.sink),
        .s1      (s1.source)
    );

    compress_packer pack_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .s1        (s1.sink),
        .out_valid (out_valid),
        .out_data  (out_data),
        .done      (done)
    );

endmodule

`default_nettype wire

/* poly_coeff_mem.sv */
// ##########################################################################
// Coefficient memory, four coefficients per word, synchronous read
// ##########################################################################
`default_nettype none
`timescale 1ns/1ps

module poly_coeff_mem (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 wr_en,
    input  compress_params_pkg::mem_addr_t       wr_addr,
    input  compress_params_pkg::mem_data_t       wr_data,
    input  logic                                 rd_en,
    input  compress_params_pkg::mem_addr_t       rd_addr,
    input  logic                                 rd_last,
    input  compress_defines_pkg::compress_mode_t rd_mode,
    compress_stage_if.source                     s0
);
    import compress_params_pkg::*;
    import compress_defines_pkg::*;

    mem_data_t mem [mem_depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            s0.data <= mem[rd_addr];
        end
    end

    // Tags follow the word through the read latency
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s0.valid <= 1'b0;
            s0.last  <= 1'b0;
            s0.mode  <= compress1;
        end else begin
            s0.valid <= rd_en;
            s0.last  <= rd_en & rd_last;
            s0.mode  <= rd_mode;
        end
    end

endmodule

`default_nettype wire
